//--- hw/router_cfg_pkg.sv
package router_cfg_pkg;

    // Pixel and address geometry
    localparam int ADDR_WIDTH      = 8;
    localparam int DATA_WIDTH      = 8;
    localparam int SPAD_N          = 8;
    localparam int SPAD_DATA_WIDTH = 64;
    localparam int ADDR_LENGTH     = 9;
    localparam int KERNEL_SIZE     = 3;

    // Byte select inside a spad word
    localparam int SPAD_SEL_WIDTH = $clog2(SPAD_N);

    // FIFO depths, both powers of two so the pointers wrap on their own
    localparam int MPP_DEPTH       = 16;
    localparam int MPP_PTR_WIDTH   = $clog2(MPP_DEPTH);
    localparam int MPP_CNT_WIDTH   = $clog2(MPP_DEPTH + 1);
    localparam int MISO_DEPTH      = 16;
    localparam int MISO_PTR_WIDTH  = $clog2(MISO_DEPTH);
    localparam int MISO_CNT_WIDTH  = $clog2(MISO_DEPTH + 1);

    // Register map
    localparam int CFG_ADDR_WIDTH  = 2;
    localparam int CFG_WDATA_WIDTH = 8;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_CTRL_ADDR  = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_CLEAR_ADDR = 2'd1;

    // Control register fields
    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_PMODE_LSB = 1;

endpackage

//--- hw/router_data_pkg.sv
package router_data_pkg;

    // One pixel address
    typedef logic [router_cfg_pkg::ADDR_WIDTH-1:0] addr_t;

    // One pixel
    typedef logic [router_cfg_pkg::DATA_WIDTH-1:0] pixel_t;

    // Address generator push, element 0 enters the queue first
    typedef addr_t [0:router_cfg_pkg::ADDR_LENGTH-1] addr_group_t;

    // Spad word, byte k holds the pixel at base address plus k
    typedef pixel_t [router_cfg_pkg::SPAD_N-1:0] spad_word_t;

    // Head of the address queue, slot 0 is the oldest entry
    typedef addr_t [router_cfg_pkg::SPAD_N-1:0] peek_t;

    // Padding mode
    // PAD_TOP zeros row 0, PAD_BOTTOM zeros the last kernel row
    // Code 3 is left unnamed and acts like PAD_NONE
    typedef enum logic [1:0] {
        PAD_NONE   = 2'd0,
        PAD_TOP    = 2'd1,
        PAD_BOTTOM = 2'd2
    } pad_mode_t;

endpackage

//--- hw/match_if.sv
`timescale 1ns/1ps

// Peek window of the address queue and the matcher's answer
interface match_if;

    router_data_pkg::peek_t            peek_addr;
    logic [router_cfg_pkg::SPAD_N-1:0] peek_valid;

    // Leading run of matched slots and their pixel bytes
    logic [router_cfg_pkg::SPAD_N-1:0] hit;
    router_data_pkg::spad_word_t       hit_data;

    modport mpp (
        output peek_addr,
        output peek_valid,
        input  hit
    );

    modport cmp (
        input  peek_addr,
        input  peek_valid,
        output hit,
        output hit_data
    );

    modport miso (
        input hit,
        input hit_data
    );

endinterface

//--- hw/mpp_fifo.sv
`timescale 1ns/1ps

module mpp_fifo (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_clear,
    input  logic                         i_write_en,
    input  router_data_pkg::addr_group_t i_data_in,
    match_if.mpp                         match,
    output logic                         o_empty
);

    router_data_pkg::addr_t mem [router_cfg_pkg::MPP_DEPTH];

    logic [router_cfg_pkg::MPP_PTR_WIDTH-1:0] rd_ptr;
    logic [router_cfg_pkg::MPP_PTR_WIDTH-1:0] wr_ptr;
    logic [router_cfg_pkg::MPP_CNT_WIDTH-1:0] count;
    logic [router_cfg_pkg::MPP_CNT_WIDTH-1:0] free;
    logic [router_cfg_pkg::MPP_CNT_WIDTH-1:0] pop_n;
    logic                                     push;

    assign free  = router_cfg_pkg::MPP_CNT_WIDTH'(router_cfg_pkg::MPP_DEPTH) - count;
    assign pop_n = router_cfg_pkg::MPP_CNT_WIDTH'($countones(match.hit));

    // Whole group or nothing
    assign push = i_write_en &&
                  (free >= router_cfg_pkg::MPP_CNT_WIDTH'(router_cfg_pkg::ADDR_LENGTH));

    assign o_empty = (count == '0);

    // Oldest SPAD_N entries, valid only where filled
    always_comb begin
        for (int k = 0; k < router_cfg_pkg::SPAD_N; k++) begin
            match.peek_addr[k]  = mem[rd_ptr + router_cfg_pkg::MPP_PTR_WIDTH'(k)];
            match.peek_valid[k] = (count > router_cfg_pkg::MPP_CNT_WIDTH'(k));
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (i_clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + pop_n[router_cfg_pkg::MPP_PTR_WIDTH-1:0];
            if (push) begin
                wr_ptr <= wr_ptr + router_cfg_pkg::MPP_PTR_WIDTH'(router_cfg_pkg::ADDR_LENGTH);
            end
            count <= count - pop_n +
                     (push ? router_cfg_pkg::MPP_CNT_WIDTH'(router_cfg_pkg::ADDR_LENGTH) : '0);
        end
    end

    always_ff @(posedge i_clk) begin
        if (push && !i_clear) begin
            for (int k = 0; k < router_cfg_pkg::ADDR_LENGTH; k++) begin
                mem[wr_ptr + router_cfg_pkg::MPP_PTR_WIDTH'(k)] <= i_data_in[k];
            end
        end
    end

    a_push_has_room: assert property (@(posedge i_clk) disable iff (!i_rst_n || i_clear)
        i_write_en |-> free >= router_cfg_pkg::MPP_CNT_WIDTH'(router_cfg_pkg::ADDR_LENGTH))
        else $error("mpp_fifo: group push dropped, only %0d free entries", free);

    // The matcher must never claim more than is queued
    a_pop_within_fill: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        pop_n <= count)
        else $error("mpp_fifo: pop of %0d with %0d queued", pop_n, count);

endmodule

//--- hw/address_comparator.sv
`timescale 1ns/1ps

module address_comparator (
    input  logic                        i_en,
    input  router_data_pkg::spad_word_t i_data,
    input  router_data_pkg::addr_t      i_addr,
    match_if.cmp                        match
);

    // One extra bit so a peek below the base shows up as a large offset
    logic [router_cfg_pkg::ADDR_WIDTH:0] offset [router_cfg_pkg::SPAD_N];
    logic [router_cfg_pkg::SPAD_N-1:0]   raw_hit;

    always_comb begin
        for (int k = 0; k < router_cfg_pkg::SPAD_N; k++) begin
            offset[k] = {1'b0, match.peek_addr[k]} - {1'b0, i_addr};
            raw_hit[k] = i_en && match.peek_valid[k] &&
                         (offset[k] < router_cfg_pkg::SPAD_N);
            match.hit_data[k] = i_data[offset[k][router_cfg_pkg::SPAD_SEL_WIDTH-1:0]];
        end
    end

    // Stop at the first miss so pixels leave in queue order
    always_comb begin
        match.hit[0] = raw_hit[0];
        for (int k = 1; k < router_cfg_pkg::SPAD_N; k++) begin
            match.hit[k] = match.hit[k-1] && raw_hit[k];
        end
    end

endmodule

//--- hw/miso_fifo.sv
`timescale 1ns/1ps

module miso_fifo #(
    parameter int INDEX = 0
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_clear,
    input  logic                       i_pop_en,
    input  router_data_pkg::pad_mode_t i_p_mode,
    match_if.miso                      match,
    output router_data_pkg::pixel_t    o_data,
    output logic                       o_valid,
    output logic                       o_empty
);

    router_data_pkg::pixel_t mem [router_cfg_pkg::MISO_DEPTH];

    logic [router_cfg_pkg::MISO_PTR_WIDTH-1:0] rd_ptr;
    logic [router_cfg_pkg::MISO_PTR_WIDTH-1:0] wr_ptr;
    logic [router_cfg_pkg::MISO_CNT_WIDTH-1:0] count;
    logic [router_cfg_pkg::MISO_CNT_WIDTH-1:0] push_n;
    logic                                      pop;
    logic                                      pad;

    assign push_n  = router_cfg_pkg::MISO_CNT_WIDTH'($countones(match.hit));
    assign pop     = i_pop_en && (count != '0);
    assign o_empty = (count == '0);

    // This row lies outside the image
    assign pad = ((i_p_mode == router_data_pkg::PAD_TOP) && (INDEX == 0)) ||
                 ((i_p_mode == router_data_pkg::PAD_BOTTOM) &&
                  (INDEX == router_cfg_pkg::KERNEL_SIZE - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            o_valid <= 1'b0;
        end else if (i_clear) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            o_valid <= 1'b0;
        end else begin
            rd_ptr  <= rd_ptr + router_cfg_pkg::MISO_PTR_WIDTH'(pop);
            wr_ptr  <= wr_ptr + push_n[router_cfg_pkg::MISO_PTR_WIDTH-1:0];
            count   <= count + push_n - router_cfg_pkg::MISO_CNT_WIDTH'(pop);
            o_valid <= pop;
        end
    end

    // Slot k of the run lands k entries past the write pointer
    always_ff @(posedge i_clk) begin
        if (!i_clear) begin
            for (int k = 0; k < router_cfg_pkg::SPAD_N; k++) begin
                if (match.hit[k]) begin
                    mem[wr_ptr + router_cfg_pkg::MISO_PTR_WIDTH'(k)] <= match.hit_data[k];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop && !i_clear) begin
            o_data <= pad ? '0 : mem[rd_ptr];
        end
    end

    // A same-edge pop frees one slot for the push
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n || i_clear)
        int'(count) + int'(push_n) <= router_cfg_pkg::MISO_DEPTH + int'(pop))
        else $error("miso_fifo: push of %0d overflows %0d held", push_n, count);

endmodule

//--- hw/router_cfg_regs.sv
`timescale 1ns/1ps

module router_cfg_regs (
    input  logic                                       i_clk,
    input  logic                                       i_rst_n,
    input  logic                                       i_cfg_we,
    input  logic [router_cfg_pkg::CFG_ADDR_WIDTH-1:0]  i_cfg_addr,
    input  logic [router_cfg_pkg::CFG_WDATA_WIDTH-1:0] i_cfg_wdata,
    output logic                                       o_ac_en,
    output router_data_pkg::pad_mode_t                 o_p_mode,
    output logic                                       o_clear
);

    logic ctrl_wr;
    logic clear_wr;

    assign ctrl_wr  = i_cfg_we && (i_cfg_addr == router_cfg_pkg::CFG_CTRL_ADDR);
    assign clear_wr = i_cfg_we && (i_cfg_addr == router_cfg_pkg::CFG_CLEAR_ADDR);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ac_en  <= 1'b0;
            o_p_mode <= router_data_pkg::PAD_NONE;
            o_clear  <= 1'b0;
        end else begin
            // Write data is ignored here, only the access matters
            o_clear <= clear_wr;
            if (ctrl_wr) begin
                o_ac_en  <= i_cfg_wdata[router_cfg_pkg::CTRL_EN_BIT];
                o_p_mode <= router_data_pkg::pad_mode_t'(
                    i_cfg_wdata[router_cfg_pkg::CTRL_PMODE_LSB +:
                                $bits(router_data_pkg::pad_mode_t)]);
            end
        end
    end

endmodule

//--- hw/row_router.sv
`timescale 1ns/1ps

module row_router #(
    parameter int INDEX = 0
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_clear,
    input  logic                         i_mpp_write_en,
    input  logic                         i_ac_en,
    input  logic                         i_miso_pop_en,
    input  router_data_pkg::pad_mode_t   i_p_mode,
    input  router_data_pkg::addr_group_t i_ag_addr,
    input  router_data_pkg::spad_word_t  i_data,
    input  router_data_pkg::addr_t       i_addr,
    input  logic                         i_data_valid,
    output router_data_pkg::pixel_t      o_data,
    output logic                         o_valid,
    output logic                         o_miso_empty,
    output logic                         o_mpp_empty
);

    logic cmp_en;

    // A word only counts in the cycle it is presented
    assign cmp_en = i_ac_en && i_data_valid;

    match_if match_bus ();

    mpp_fifo i_mpp_fifo (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clear    (i_clear),
        .i_write_en (i_mpp_write_en),
        .i_data_in  (i_ag_addr),
        .match      (match_bus.mpp),
        .o_empty    (o_mpp_empty)
    );

    address_comparator i_address_comparator (
        .i_en   (cmp_en),
        .i_data (i_data),
        .i_addr (i_addr),
        .match  (match_bus.cmp)
    );

    miso_fifo #(
        .INDEX (INDEX)
    ) i_miso_fifo (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_clear  (i_clear),
        .i_pop_en (i_miso_pop_en),
        .i_p_mode (i_p_mode),
        .match    (match_bus.miso),
        .o_data   (o_data),
        .o_valid  (o_valid),
        .o_empty  (o_miso_empty)
    );

endmodule

//--- hw/row_router_top.sv
`timescale 1ns/1ps

module row_router_top #(
    parameter int INDEX = 0
) (
    input  logic                                       i_clk,
    input  logic                                       i_rst_n,
    input  logic                                       i_cfg_we,
    input  logic [router_cfg_pkg::CFG_ADDR_WIDTH-1:0]  i_cfg_addr,
    input  logic [router_cfg_pkg::CFG_WDATA_WIDTH-1:0] i_cfg_wdata,
    input  logic                                       i_mpp_write_en,
    input  logic [router_cfg_pkg::ADDR_LENGTH*router_cfg_pkg::ADDR_WIDTH-1:0] i_ag_addr,
    input  logic [router_cfg_pkg::SPAD_DATA_WIDTH-1:0] i_spad_data,
    input  logic [router_cfg_pkg::ADDR_WIDTH-1:0]      i_spad_addr,
    input  logic                                       i_spad_valid,
    input  logic                                       i_miso_pop_en,
    output logic [router_cfg_pkg::DATA_WIDTH-1:0]      o_data,
    output logic                                       o_valid,
    output logic                                       o_miso_empty,
    output logic                                       o_mpp_empty
);

    logic                       ac_en;
    logic                       clear;
    router_data_pkg::pad_mode_t p_mode;

    router_cfg_regs i_router_cfg_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_ac_en     (ac_en),
        .o_p_mode    (p_mode),
        .o_clear     (clear)
    );

    // Flat buses map element 0 and byte 0 as the packed types define them
    row_router #(
        .INDEX (INDEX)
    ) i_row_router (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_clear        (clear),
        .i_mpp_write_en (i_mpp_write_en),
        .i_ac_en        (ac_en),
        .i_miso_pop_en  (i_miso_pop_en),
        .i_p_mode       (p_mode),
        .i_ag_addr      (router_data_pkg::addr_group_t'(i_ag_addr)),
        .i_data         (router_data_pkg::spad_word_t'(i_spad_data)),
        .i_addr         (i_spad_addr),
        .i_data_valid   (i_spad_valid),
        .o_data         (o_data),
        .o_valid        (o_valid),
        .o_miso_empty   (o_miso_empty),
        .o_mpp_empty    (o_mpp_empty)
    );

endmodule

//--- testbench/tb_row_router.sv
`timescale 1ns/1ps

module tb_row_router;

    localparam int INDEX = 0;
    // Roughly 700 cycles of tests, so this only trips on a hang
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int AW = router_cfg_pkg::ADDR_WIDTH;
    localparam int DW = router_cfg_pkg::DATA_WIDTH;
    localparam int GROUP_N = router_cfg_pkg::ADDR_LENGTH;

    logic                                       i_clk;
    logic                                       i_rst_n;
    logic                                       i_cfg_we;
    logic [router_cfg_pkg::CFG_ADDR_WIDTH-1:0]  i_cfg_addr;
    logic [router_cfg_pkg::CFG_WDATA_WIDTH-1:0] i_cfg_wdata;
    logic                                       i_mpp_write_en;
    logic [GROUP_N*AW-1:0]                      i_ag_addr;
    logic [router_cfg_pkg::SPAD_DATA_WIDTH-1:0] i_spad_data;
    logic [AW-1:0]                              i_spad_addr;
    logic                                       i_spad_valid;
    logic                                       i_miso_pop_en;
    logic [DW-1:0]                              o_data;
    logic                                       o_valid;
    logic                                       o_miso_empty;
    logic                                       o_mpp_empty;

    // Reference model state
    logic [AW-1:0] addr_q [$];
    logic [DW-1:0] pix_q [$];
    logic [AW-1:0] grp [GROUP_N];
    logic          model_en;
    logic [1:0]    model_pmode;
    integer        seed = 75729;
    int            cycle_count = 0;

    row_router_top #(
        .INDEX (INDEX)
    ) i_row_router_top (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cfg_we       (i_cfg_we),
        .i_cfg_addr     (i_cfg_addr),
        .i_cfg_wdata    (i_cfg_wdata),
        .i_mpp_write_en (i_mpp_write_en),
        .i_ag_addr      (i_ag_addr),
        .i_spad_data    (i_spad_data),
        .i_spad_addr    (i_spad_addr),
        .i_spad_valid   (i_spad_valid),
        .i_miso_pop_en  (i_miso_pop_en),
        .o_data         (o_data),
        .o_valid        (o_valid),
        .o_miso_empty   (o_miso_empty),
        .o_mpp_empty    (o_mpp_empty)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Kernel row style group, consecutive addresses with some repeats
    task automatic new_group();
        grp[0] = $random(seed);
        for (int k = 1; k < GROUP_N; k++) begin
            grp[k] = grp[k-1] + AW'($random(seed) & 1);
        end
    endtask

    // Base at or a little below the head address
    function automatic logic [AW-1:0] head_base();
        int back;
        back = $unsigned($random(seed)) % 4;
        if (int'(addr_q[0]) < back) begin
            back = int'(addr_q[0]);
        end
        return addr_q[0] - AW'(back);
    endfunction

    // Drive one cycle on the falling edge, step the model, check after the edge
    task automatic run_cycle(input logic push, input logic spad_v, input logic [AW-1:0] base,
                             input logic [63:0] word, input logic pop);
        int            hits;
        int            off;
        logic          exp_valid;
        logic          pad;
        logic [DW-1:0] exp_data;
        i_mpp_write_en = push;
        for (int k = 0; k < GROUP_N; k++) begin
            i_ag_addr[(GROUP_N-1-k)*AW +: AW] = grp[k];
        end
        i_spad_valid  = spad_v;
        i_spad_addr   = base;
        i_spad_data   = word;
        i_miso_pop_en = pop;
        pad = ((model_pmode == 2'd1) && (INDEX == 0)) ||
              ((model_pmode == 2'd2) && (INDEX == router_cfg_pkg::KERNEL_SIZE - 1));
        // Pop sees the fill level from before this edge
        exp_valid = pop && (pix_q.size() > 0);
        exp_data  = '0;
        if (exp_valid) begin
            exp_data = pix_q.pop_front();
            if (pad) begin
                exp_data = '0;
            end
        end
        hits = 0;
        while (spad_v && model_en && hits < router_cfg_pkg::SPAD_N && hits < addr_q.size()) begin
            off = int'(addr_q[hits]) - int'(base);
            if (off < 0 || off >= router_cfg_pkg::SPAD_N) begin
                break;
            end
            pix_q.push_back(word[off*DW +: DW]);
            hits++;
        end
        repeat (hits) void'(addr_q.pop_front());
        if (push) begin
            for (int k = 0; k < GROUP_N; k++) begin
                addr_q.push_back(grp[k]);
            end
        end
        @(negedge i_clk);
        check_value("o_valid", 64'(exp_valid), 64'(o_valid));
        if (exp_valid) begin
            check_value("o_data", 64'(exp_data), 64'(o_data));
        end
        check_value("o_mpp_empty", 64'(addr_q.size() == 0), 64'(o_mpp_empty));
        check_value("o_miso_empty", 64'(pix_q.size() == 0), 64'(o_miso_empty));
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
        i_mpp_write_en = 1'b0;
        i_spad_valid   = 1'b0;
        i_miso_pop_en  = 1'b0;
        i_cfg_we       = 1'b1;
        i_cfg_addr     = addr;
        i_cfg_wdata    = data;
        @(negedge i_clk);
        i_cfg_we = 1'b0;
        if (addr == router_cfg_pkg::CFG_CTRL_ADDR) begin
            model_en    = data[0];
            model_pmode = data[2:1];
        end else if (addr == router_cfg_pkg::CFG_CLEAR_ADDR) begin
            // The pulse clears the FIFOs one edge later
            @(negedge i_clk);
            addr_q.delete();
            pix_q.delete();
        end
    endtask

    task automatic fetch_all();
        logic [63:0] word;
        while (addr_q.size() > 0) begin
            word = {$random(seed), $random(seed)};
            run_cycle(1'b0, 1'b1, head_base(), word, 1'($random(seed) & 1));
        end
    endtask

    task automatic drain();
        while (pix_q.size() > 0) begin
            run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
        end
    endtask

    initial begin
        logic          do_push;
        logic          do_spad;
        logic [AW-1:0] base;
        logic [63:0]   word;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_cfg_we = 1'b0;
        i_cfg_addr = '0;
        i_cfg_wdata = '0;
        i_mpp_write_en = 1'b0;
        i_ag_addr = '0;
        i_spad_data = '0;
        i_spad_addr = '0;
        i_spad_valid = 1'b0;
        i_miso_pop_en = 1'b0;
        model_en = 1'b0;
        model_pmode = 2'd0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // Reset state and a pop on the empty MISO
        check_value("o_mpp_empty", 64'd1, 64'(o_mpp_empty));
        check_value("o_miso_empty", 64'd1, 64'(o_miso_empty));
        check_value("o_valid", 64'd0, 64'(o_valid));
        run_cycle(1'b0, 1'b0, '0, '0, 1'b1);

        // Ordered fetch
        write_cfg(router_cfg_pkg::CFG_CTRL_ADDR, 8'h01);
        repeat (4) begin
            new_group();
            run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
            fetch_all();
            drain();
        end

        // Word missing the head, then a covering word while disabled
        new_group();
        run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
        run_cycle(1'b0, 1'b1, addr_q[0] + 1'b1, {$random(seed), $random(seed)}, 1'b0);
        write_cfg(router_cfg_pkg::CFG_CTRL_ADDR, 8'h00);
        run_cycle(1'b0, 1'b1, addr_q[0], {$random(seed), $random(seed)}, 1'b0);
        write_cfg(router_cfg_pkg::CFG_CTRL_ADDR, 8'h01);
        fetch_all();
        drain();

        // Top padding zeros row 0, bottom padding leaves it alone
        write_cfg(router_cfg_pkg::CFG_CTRL_ADDR, 8'h03);
        new_group();
        run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
        fetch_all();
        drain();
        write_cfg(router_cfg_pkg::CFG_CTRL_ADDR, 8'h05);
        new_group();
        run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
        fetch_all();
        drain();

        // Clear with both FIFOs holding data
        write_cfg(router_cfg_pkg::CFG_CTRL_ADDR, 8'h01);
        new_group();
        run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
        run_cycle(1'b0, 1'b1, addr_q[0], {$random(seed), $random(seed)}, 1'b0);
        write_cfg(router_cfg_pkg::CFG_CLEAR_ADDR, 8'h00);
        check_value("o_mpp_empty", 64'd1, 64'(o_mpp_empty));
        check_value("o_miso_empty", 64'd1, 64'(o_miso_empty));
        new_group();
        run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
        fetch_all();
        drain();

        // Mixed random traffic kept within both FIFO depths
        repeat (300) begin
            do_push = (($random(seed) & 3) == 0) &&
                      (addr_q.size() <= router_cfg_pkg::MPP_DEPTH - GROUP_N);
            if (do_push) begin
                new_group();
            end
            do_spad = ($random(seed) & 1) &&
                      (pix_q.size() <= router_cfg_pkg::MISO_DEPTH - router_cfg_pkg::SPAD_N);
            if (addr_q.size() > 0 && ($random(seed) & 3) != 0) begin
                base = head_base();
            end else begin
                base = $random(seed);
            end
            word = {$random(seed), $random(seed)};
            run_cycle(do_push, do_spad, base, word, 1'($random(seed) & 1));
        end
        drain();
        run_cycle(1'b0, 1'b0, '0, '0, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- src.f
hw/router_cfg_pkg.sv
hw/router_data_pkg.sv
hw/match_if.sv
hw/mpp_fifo.sv
hw/address_comparator.sv
hw/miso_fifo.sv
hw/router_cfg_regs.sv
hw/row_router.sv
hw/row_router_top.sv
testbench/tb_row_router.sv

//--- Bender.yml
package:
  name: row_router

sources:
  - hw/router_cfg_pkg.sv
  - hw/router_data_pkg.sv
  - hw/match_if.sv
  - hw/mpp_fifo.sv
  - hw/address_comparator.sv
  - hw/miso_fifo.sv
  - hw/router_cfg_regs.sv
  - hw/row_router.sv
  - hw/row_router_top.sv
  - target: test
    files:
      - testbench/tb_row_router.sv
